/* mem_access_pkg.sv */
// shared widths and enums for the load/store unit, compiled ahead of every rtl file
package mem_access_pkg;

   localparam int DATA_W = 32;  // one memory word
   localparam int CTRL_W = 3;   // size in bits 1:0, zero extend in bit 2

   // access size from code bits 1:0
   typedef enum logic [1:0] {
      size_byte = 2'd0,
      size_half = 2'd1,
      size_word = 2'd2
   } access_size_t;

   // splitter sequencer
   typedef enum logic [2:0] {
      st_idle      = 3'd0,
      st_issue     = 3'd1,  // strobe goes out once memory busy is low
      st_wait_ack  = 3'd2,
      st_wait_done = 3'd3,
      st_finish    = 3'd4
   } split_state_t;

   // memory controller
   typedef enum logic [1:0] {
      cs_clear   = 2'd0,    // zero sweep after reset
      cs_idle    = 2'd1,
      cs_access  = 2'd2,
      cs_refresh = 2'd3
   } ctrl_state_t;

endpackage

/* access_splitter.sv */
// input side of the load/store unit, turns one core request into one or two word transfers
`timescale 1ns/100ps

module access_splitter #(
   parameter int ADDR_W = 4
) (
   input  logic                                  clk,
   input  logic                                  i_reset,
   input  logic                                  i_rd_en,
   input  logic                                  i_wr_en,
   input  logic [31:0]                           i_addr,
   input  logic [mem_access_pkg::DATA_W-1:0]     i_wdata,
   input  logic [mem_access_pkg::CTRL_W-1:0]     i_ctrl,
   input  logic                                  i_mem_busy,
   input  logic                                  i_init_done,
   output logic                                  o_busy,
   output logic                                  o_mem_rd,
   output logic                                  o_mem_wr,
   output logic [ADDR_W-1:0]                     o_mem_addr,
   output logic [mem_access_pkg::DATA_W-1:0]     o_mem_wdata,
   output logic [mem_access_pkg::DATA_W/8-1:0]   o_mem_mask,
   output logic                                  o_cap_lo,
   output logic                                  o_cap_hi,
   output logic [1:0]                            o_offset,
   output mem_access_pkg::access_size_t          o_size,
   output logic                                  o_unsigned
);
   import mem_access_pkg::*;

   localparam int NB = DATA_W / 8;  // byte lanes

   split_state_t        state;
   logic                r_is_rd;
   logic                r_two;       // access spills into the next word
   logic                r_beat;      // 0 first word, 1 second word
   logic [DATA_W-1:0]   r_wdata_hi;
   logic [NB-1:0]       r_mask_hi;

   logic                accept;
   logic                beat_done;
   logic                next_beat;
   logic [DATA_W-1:0]   wdata_ext;
   logic [NB-1:0]       size_mask;
   logic [2:0]          size_bytes;
   logic [3:0]          end_byte;
   logic [2*DATA_W-1:0] wdata_pair;
   logic [2*NB-1:0]     mask_pair;

   // clear unused upper data bits, pick lane mask and byte count
   always_comb begin
      case (access_size_t'(i_ctrl[1:0]))
         size_byte: begin
            wdata_ext  = {{(DATA_W-8){1'b0}}, i_wdata[7:0]};
            size_mask  = NB'(1);
            size_bytes = 3'd1;
         end
         size_half: begin
            wdata_ext  = {{(DATA_W-16){1'b0}}, i_wdata[15:0]};
            size_mask  = NB'(3);
            size_bytes = 3'd2;
         end
         default: begin
            wdata_ext  = i_wdata;
            size_mask  = '1;
            size_bytes = 3'd4;
         end
      endcase
   end

   // place data and mask across the two word pair, low half is beat one
   assign wdata_pair = {{DATA_W{1'b0}}, wdata_ext} << {i_addr[1:0], 3'b000};
   assign mask_pair  = {{NB{1'b0}}, size_mask} << i_addr[1:0];
   assign end_byte   = {2'b00, i_addr[1:0]} + {1'b0, size_bytes};

   assign accept    = (state == st_idle) && i_init_done && (i_rd_en || i_wr_en);
   assign beat_done = (state == st_wait_done) && !i_mem_busy;
   assign next_beat = beat_done && r_two && !r_beat;

   assign o_busy   = (state != st_idle) || !i_init_done;
   assign o_mem_rd = (state == st_issue) && !i_mem_busy && r_is_rd;
   assign o_mem_wr = (state == st_issue) && !i_mem_busy && !r_is_rd;
   assign o_cap_lo = beat_done && r_is_rd && !r_beat;
   assign o_cap_hi = beat_done && r_is_rd && r_beat;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         state   <= st_idle;
         r_is_rd <= 1'b0;
         r_two   <= 1'b0;
         r_beat  <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               if (accept) begin
                  state   <= st_issue;
                  r_is_rd <= i_rd_en;          // read wins over write
                  r_two   <= (end_byte > 4'd4);
                  r_beat  <= 1'b0;
               end
            end
            st_issue: begin
               if (!i_mem_busy)
                  state <= st_wait_ack;
            end
            st_wait_ack: begin
               if (i_mem_busy)                 // controller took the strobe
                  state <= st_wait_done;
            end
            st_wait_done: begin
               if (next_beat) begin
                  state  <= st_issue;
                  r_beat <= 1'b1;
               end else if (beat_done) begin
                  state <= st_finish;
               end
            end
            st_finish: state <= st_idle;
            default:   state <= st_idle;
         endcase
      end
   end

   // request payload, loaded on accept and swapped for the second beat
   always_ff @(posedge clk) begin
      if (accept) begin
         o_mem_addr  <= i_addr[ADDR_W+1:2];
         o_mem_wdata <= wdata_pair[DATA_W-1:0];
         o_mem_mask  <= mask_pair[NB-1:0];
         r_wdata_hi  <= wdata_pair[2*DATA_W-1:DATA_W];
         r_mask_hi   <= mask_pair[2*NB-1:NB];
         o_offset    <= i_addr[1:0];
         o_size      <= access_size_t'(i_ctrl[1:0]);
         o_unsigned  <= i_ctrl[2];
      end else if (next_beat) begin
         o_mem_addr  <= o_mem_addr + 1'b1;    // wraps at memory depth
         o_mem_wdata <= r_wdata_hi;
         o_mem_mask  <= r_mask_hi;
      end
   end

endmodule

/* word_mem_ctrl.sv */
// word memory with fixed access latency, refresh windows and a zero sweep after reset
`timescale 1ns/100ps

module word_mem_ctrl #(
   parameter int ADDR_W           = 4,
   parameter int ACCESS_CYCLES    = 3,
   parameter int REFRESH_INTERVAL = 40,
   parameter int REFRESH_CYCLES   = 5
) (
   input  logic                                clk,
   input  logic                                i_reset,
   input  logic                                i_rd,
   input  logic                                i_wr,
   input  logic [ADDR_W-1:0]                   i_addr,
   input  logic [mem_access_pkg::DATA_W-1:0]   i_wdata,
   input  logic [mem_access_pkg::DATA_W/8-1:0] i_mask,
   output logic                                o_busy,
   output logic [mem_access_pkg::DATA_W-1:0]   o_rdata,
   output logic                                o_init_done
);
   import mem_access_pkg::*;

   localparam int NB      = DATA_W / 8;
   localparam int DEPTH   = 2 ** ADDR_W;
   localparam int MAX_CYC = (ACCESS_CYCLES > REFRESH_CYCLES) ? ACCESS_CYCLES : REFRESH_CYCLES;
   localparam int CNT_W   = $clog2(MAX_CYC + 1);
   localparam int REF_W   = $clog2(REFRESH_INTERVAL + 1);

   logic [DATA_W-1:0] mem [DEPTH];
   ctrl_state_t       state;
   logic [ADDR_W-1:0] clr_addr;
   logic [CNT_W-1:0]  cyc_cnt;    // busy cycles left after this one
   logic [REF_W-1:0]  ref_cnt;
   logic              refresh_due;
   logic              start_access;
   logic              start_refresh;
   logic              done_access;

   logic [ADDR_W-1:0] r_addr;
   logic [DATA_W-1:0] r_wdata;
   logic [NB-1:0]     r_mask;
   logic              r_wr;

   assign refresh_due   = (ref_cnt == REF_W'(REFRESH_INTERVAL));
   assign start_access  = (state == cs_idle) && (i_rd || i_wr);
   assign start_refresh = (state == cs_idle) && !i_rd && !i_wr && refresh_due;  // strobe wins
   assign done_access   = (state == cs_access) && (cyc_cnt == '0);

   // interval counter, holds at the limit until a window can start
   always_ff @(posedge clk) begin
      if (i_reset)
         ref_cnt <= '0;
      else if (start_refresh)
         ref_cnt <= '0;
      else if (!refresh_due)
         ref_cnt <= ref_cnt + 1'b1;
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         state       <= cs_clear;
         clr_addr    <= '0;
         cyc_cnt     <= '0;
         o_busy      <= 1'b1;
         o_init_done <= 1'b0;
      end else begin
         case (state)
            cs_clear: begin
               clr_addr <= clr_addr + 1'b1;
               if (clr_addr == '1) begin      // last word cleared
                  state       <= cs_idle;
                  o_busy      <= 1'b0;
                  o_init_done <= 1'b1;
               end
            end
            cs_idle: begin
               if (start_access) begin
                  state   <= cs_access;
                  o_busy  <= 1'b1;
                  cyc_cnt <= CNT_W'(ACCESS_CYCLES - 1);
               end else if (start_refresh) begin
                  state   <= cs_refresh;
                  o_busy  <= 1'b1;
                  cyc_cnt <= CNT_W'(REFRESH_CYCLES - 1);
               end
            end
            cs_access, cs_refresh: begin
               if (cyc_cnt == '0) begin
                  state  <= cs_idle;
                  o_busy <= 1'b0;
               end else begin
                  cyc_cnt <= cyc_cnt - 1'b1;
               end
            end
            default: state <= cs_idle;
         endcase
      end
   end

   // capture the request with its strobe
   always_ff @(posedge clk) begin
      if (start_access) begin
         r_addr  <= i_addr;
         r_wdata <= i_wdata;
         r_mask  <= i_mask;
         r_wr    <= i_wr;
      end
   end

   // array port, the access lands in the last busy cycle
   always_ff @(posedge clk) begin
      if (state == cs_clear) begin
         mem[clr_addr] <= '0;
      end else if (done_access && r_wr) begin
         for (int b = 0; b < NB; b++) begin
            if (r_mask[b])
               mem[r_addr][8*b +: 8] <= r_wdata[8*b +: 8];
         end
      end
      if (done_access && !r_wr)
         o_rdata <= mem[r_addr];             // held until the next read
   end

endmodule

/* load_aligner.sv */
// output side of the load/store unit, realigns the captured words and extends the load value
`timescale 1ns/100ps

module load_aligner (
   input  logic                              clk,
   input  logic                              i_reset,
   input  logic                              i_cap_lo,
   input  logic                              i_cap_hi,
   input  logic [mem_access_pkg::DATA_W-1:0] i_mem_rdata,
   input  logic [1:0]                        i_offset,
   input  mem_access_pkg::access_size_t      i_size,
   input  logic                              i_unsigned,
   output logic [mem_access_pkg::DATA_W-1:0] o_rdata
);
   import mem_access_pkg::*;

   logic [DATA_W-1:0]   r_lo;
   logic [DATA_W-1:0]   r_hi;
   logic [1:0]          r_offset;
   access_size_t        r_size;
   logic                r_unsigned;
   logic [2*DATA_W-1:0] pair_shift;

   // load info is taken with the low word so o_rdata holds across writes
   always_ff @(posedge clk) begin
      if (i_reset) begin
         r_lo       <= '0;
         r_hi       <= '0;
         r_offset   <= 2'd0;
         r_size     <= size_word;
         r_unsigned <= 1'b0;
      end else begin
         if (i_cap_lo) begin
            r_lo       <= i_mem_rdata;
            r_offset   <= i_offset;
            r_size     <= i_size;
            r_unsigned <= i_unsigned;
         end
         if (i_cap_hi)
            r_hi <= i_mem_rdata;
      end
   end

   assign pair_shift = {r_hi, r_lo} >> {r_offset, 3'b000};

   always_comb begin
      case (r_size)
         size_byte: o_rdata = r_unsigned ? {{(DATA_W-8){1'b0}}, pair_shift[7:0]}
                                         : {{(DATA_W-8){pair_shift[7]}}, pair_shift[7:0]};
         size_half: o_rdata = r_unsigned ? {{(DATA_W-16){1'b0}}, pair_shift[15:0]}
                                         : {{(DATA_W-16){pair_shift[15]}}, pair_shift[15:0]};
         default:   o_rdata = pair_shift[DATA_W-1:0];
      endcase
   end

endmodule

/* unaligned_mem_top.sv */
// top of the load/store unit, wires splitter, word memory controller and load aligner together
`timescale 1ns/100ps

module unaligned_mem_top #(
   parameter int ADDR_W           = 4,
   parameter int ACCESS_CYCLES    = 3,
   parameter int REFRESH_INTERVAL = 40,
   parameter int REFRESH_CYCLES   = 5
) (
   input  logic                              clk,
   input  logic                              i_reset,
   input  logic                              i_rd_en,
   input  logic                              i_wr_en,
   input  logic [31:0]                       i_addr,
   input  logic [mem_access_pkg::DATA_W-1:0] i_wdata,
   input  logic [mem_access_pkg::CTRL_W-1:0] i_ctrl,
   output logic [mem_access_pkg::DATA_W-1:0] o_rdata,
   output logic                              o_busy,
   output logic                              o_init_done
);
   import mem_access_pkg::*;

   logic                mem_rd;
   logic                mem_wr;
   logic                mem_busy;
   logic [ADDR_W-1:0]   mem_addr;
   logic [DATA_W-1:0]   mem_wdata;
   logic [DATA_W-1:0]   mem_rdata;
   logic [DATA_W/8-1:0] mem_mask;
   logic                cap_lo;
   logic                cap_hi;
   logic [1:0]          ld_offset;
   access_size_t        ld_size;
   logic                ld_unsigned;

   access_splitter #(
      .ADDR_W (ADDR_W)
   ) access_splitter_inst (
      .clk         (clk),
      .i_reset     (i_reset),
      .i_rd_en     (i_rd_en),
      .i_wr_en     (i_wr_en),
      .i_addr      (i_addr),
      .i_wdata     (i_wdata),
      .i_ctrl      (i_ctrl),
      .i_mem_busy  (mem_busy),
      .i_init_done (o_init_done),
      .o_busy      (o_busy),
      .o_mem_rd    (mem_rd),
      .o_mem_wr    (mem_wr),
      .o_mem_addr  (mem_addr),
      .o_mem_wdata (mem_wdata),
      .o_mem_mask  (mem_mask),
      .o_cap_lo    (cap_lo),
      .o_cap_hi    (cap_hi),
      .o_offset    (ld_offset),
      .o_size      (ld_size),
      .o_unsigned  (ld_unsigned)
   );

   word_mem_ctrl #(
      .ADDR_W           (ADDR_W),
      .ACCESS_CYCLES    (ACCESS_CYCLES),
      .REFRESH_INTERVAL (REFRESH_INTERVAL),
      .REFRESH_CYCLES   (REFRESH_CYCLES)
   ) word_mem_ctrl_inst (
      .clk         (clk),
      .i_reset     (i_reset),
      .i_rd        (mem_rd),
      .i_wr        (mem_wr),
      .i_addr      (mem_addr),
      .i_wdata     (mem_wdata),
      .i_mask      (mem_mask),
      .o_busy      (mem_busy),
      .o_rdata     (mem_rdata),
      .o_init_done (o_init_done)
   );

   load_aligner load_aligner_inst (
      .clk         (clk),
      .i_reset     (i_reset),
      .i_cap_lo    (cap_lo),
      .i_cap_hi    (cap_hi),
      .i_mem_rdata (mem_rdata),
      .i_offset    (ld_offset),
      .i_size      (ld_size),
      .i_unsigned  (ld_unsigned),
      .o_rdata     (o_rdata)
   );

endmodule

/* tb_unaligned_mem.sv */
// simulation top that drives unaligned_mem_top with lfsr loads and stores checked against a byte-array model
`timescale 1ns/100ps

module tb_unaligned_mem;

   localparam int ADDR_W           = 4;
   localparam int ACCESS_CYCLES    = 3;
   localparam int REFRESH_INTERVAL = 40;
   localparam int REFRESH_CYCLES   = 5;
   localparam int MEM_BYTES        = 4 * (2 ** ADDR_W);
   localparam int WAIT_LIMIT       = 200;  // cycles to wait, well above refresh plus a split access

   logic        clk = 1'b0;
   logic        i_reset;
   logic        i_rd_en;
   logic        i_wr_en;
   logic [31:0] i_addr;
   logic [31:0] i_wdata;
   logic [2:0]  i_ctrl;
   logic [31:0] o_rdata;
   logic        o_busy;
   logic        o_init_done;

   logic [7:0]  mem_model [MEM_BYTES];
   logic [15:0] lfsr_state = 16'd2;
   int          errors = 0;
   int          timeouts = 0;

   unaligned_mem_top #(
      .ADDR_W           (ADDR_W),
      .ACCESS_CYCLES    (ACCESS_CYCLES),
      .REFRESH_INTERVAL (REFRESH_INTERVAL),
      .REFRESH_CYCLES   (REFRESH_CYCLES)
   ) unaligned_mem_top_inst (
      .clk         (clk),
      .i_reset     (i_reset),
      .i_rd_en     (i_rd_en),
      .i_wr_en     (i_wr_en),
      .i_addr      (i_addr),
      .i_wdata     (i_wdata),
      .i_ctrl      (i_ctrl),
      .o_rdata     (o_rdata),
      .o_busy      (o_busy),
      .o_init_done (o_init_done)
   );

   always #2 clk = ~clk;  // 4 ns period

   // fibonacci lfsr x^16+x^14+x^13+x^11+1 stepped once per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
         lfsr_state = {lfsr_state[14:0], fb};
         v = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic int size_bytes(input logic [2:0] ctrl);
      return (ctrl[1:0] == 2'd0) ? 1 : (ctrl[1:0] == 2'd1) ? 2 : 4;
   endfunction

   // little endian load that wraps at the top of memory
   function automatic logic [31:0] model_load(input logic [31:0] addr, input logic [2:0] ctrl);
      logic [31:0] v;
      int          nb;
      v  = '0;
      nb = size_bytes(ctrl);
      for (int i = 0; i < nb; i++)
         v[8*i +: 8] = mem_model[(int'(addr[5:0]) + i) % MEM_BYTES];
      if (!ctrl[2] && nb == 1)
         v = {{24{v[7]}}, v[7:0]};
      else if (!ctrl[2] && nb == 2)
         v = {{16{v[15]}}, v[15:0]};
      return v;
   endfunction

   task automatic model_store(input logic [31:0] addr, input logic [2:0] ctrl,
                              input logic [31:0] data);
      for (int i = 0; i < size_bytes(ctrl); i++)
         mem_model[(int'(addr[5:0]) + i) % MEM_BYTES] = data[8*i +: 8];
   endtask

   task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s expected %h actual %h", $time, what, exp, act);
      end
   endtask

   // returns on the first falling edge with o_busy low
   task automatic wait_not_busy(input string what);
      int n;
      n = 0;
      while (o_busy && n < WAIT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (o_busy) begin
         timeouts++;
         $display("timeout at %0t: o_busy stayed high while waiting for %s", $time, what);
      end
   endtask

   task automatic access(input logic rd, input logic [2:0] ctrl, input logic [31:0] addr,
                         input logic [31:0] data);
      wait_not_busy("a free request slot");
      i_rd_en = rd;
      i_wr_en = !rd;
      i_addr  = addr;
      i_wdata = data;
      i_ctrl  = ctrl;
      @(negedge clk);   // accepted on the edge just passed
      i_rd_en = 1'b0;
      i_wr_en = 1'b0;
      check_value("o_busy after request", 32'd1, {31'd0, o_busy});
      wait_not_busy("request completion");
      if (rd)
         check_value($sformatf("load addr %h ctrl %0d", addr, ctrl), model_load(addr, ctrl),
                     o_rdata);
      else
         model_store(addr, ctrl, data);
   endtask

   task automatic check_all_words();
      for (int w = 0; w < MEM_BYTES / 4; w++)
         access(1'b1, 3'd2, 32'(4 * w), 32'd0);
   endtask

   task automatic random_ops(input int count);
      logic        rd;
      logic [2:0]  ctrl;
      logic [31:0] a;
      logic [31:0] d;
      for (int n = 0; n < count; n++) begin
         rd        = 1'(rand_bits(1));
         ctrl[1:0] = 2'(rand_bits(2));
         if (ctrl[1:0] == 2'd3)
            ctrl[1:0] = 2'd2;   // size 3 maps to word
         ctrl[2]   = 1'(rand_bits(1));
         a         = rand_bits(8);   // upper bits beyond memory just wrap
         d         = rand_bits(32);
         access(rd, ctrl, a, d);
      end
   endtask

   // write strobe held during a busy load and dropped before busy falls
   task automatic ignored_strobe(input logic [31:0] addr);
      wait_not_busy("a free request slot");
      i_rd_en = 1'b1;
      i_addr  = addr + 32'd8;
      i_ctrl  = 3'd2;
      @(negedge clk);
      i_rd_en = 1'b0;
      i_wr_en = 1'b1;
      i_addr  = addr;
      i_wdata = 32'hdead_beef;
      repeat (2) @(negedge clk);
      if (!o_busy) begin
         errors++;
         $display("at %0t: load finished before the ignored strobe was dropped", $time);
      end
      i_wr_en = 1'b0;
      wait_not_busy("load under ignored strobe");
      check_value("load under ignored strobe", model_load(addr + 32'd8, 3'd2), o_rdata);
      access(1'b1, 3'd2, addr, 32'd0);   // model still holds the old word
   endtask

   initial begin
      int          ua_addr [9];
      logic [31:0] a;
      logic [2:0]  sz;
      int          n;
      ua_addr = '{3, 7, 63, 1, 22, 31, 61, 62, 63};
      i_reset = 1'b1;
      i_rd_en = 1'b0;
      i_wr_en = 1'b0;
      i_addr  = '0;
      i_wdata = '0;
      i_ctrl  = '0;
      for (int i = 0; i < MEM_BYTES; i++)
         mem_model[i] = 8'h00;
      repeat (16) @(negedge clk);
      i_reset = 1'b0;

      // clear sweep still running
      check_value("o_busy after reset", 32'd1, {31'd0, o_busy});
      check_value("o_init_done after reset", 32'd0, {31'd0, o_init_done});
      n = 0;
      while (!o_init_done && n < WAIT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (!o_init_done) begin
         timeouts++;
         $display("timeout at %0t: o_init_done never rose after reset", $time);
      end
      check_all_words();

      // aligned stores and loads of each size
      for (int s = 0; s < 3; s++) begin
         sz = 3'(s);
         for (int k = 0; k < 6; k++) begin
            a = rand_bits(6) & ~((32'd1 << s) - 32'd1);
            access(1'b0, sz, a, rand_bits(32));
            access(1'b1, sz, a, 32'd0);
            access(1'b1, sz | 3'd4, a, 32'd0);
         end
      end
      check_all_words();

      // stores across a word boundary where the top address wraps to word 0
      for (int i = 0; i < 9; i++) begin
         sz = (i < 3) ? 3'd1 : 3'd2;
         access(1'b0, sz, 32'(ua_addr[i]), rand_bits(32));
         access(1'b1, 3'd2, 32'(ua_addr[i]), 32'd0);
      end
      check_all_words();

      random_ops(400);
      random_ops(1200);   // spans many refresh windows
      ignored_strobe(32'd12);
      ignored_strobe(32'd60);
      check_all_words();

      $display("errors: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

/* all.f */
mem_access_pkg.sv
access_splitter.sv
word_mem_ctrl.sv
load_aligner.sv
unaligned_mem_top.sv
tb_unaligned_mem.sv
